// File: verilog/elink_pkg.sv
package elink_pkg;

  typedef struct packed {
    logic       is_k;   // K-character flag
    logic [7:0] value;
  } symbol_t;

  typedef logic [75:0] frame_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;   // Word address
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  localparam logic [7:0] k28_5 = 8'hbc;  // Idle comma
  localparam logic [7:0] k28_1 = 8'h3c;  // Start of frame
  localparam logic [7:0] k28_3 = 8'h7c;  // End of frame

  localparam int frame_bytes = 10;

  typedef enum logic [2:0] {
    tx0  = 3'd0,
    tx1  = 3'd1,
    tx2  = 3'd2,
    ctrl = 3'd3,
    rx0  = 3'd4,
    rx1  = 3'd5,
    rx2  = 3'd6
  } reg_addr_e;

  typedef enum logic [1:0] {idle, sop, data, eop} framer_state_e;

  typedef enum logic {hunt, collect} deframer_state_e;

endpackage

// File: verilog/elink_wb_regs.sv
`timescale 1ns/1ns
module elink_wb_regs import elink_pkg::*; (
  input  logic    clk_40,
  input  logic    reset,
  input  wb_req_t wb_req,
  input  logic    tx_busy,
  input  logic    rx_frame_valid,
  input  frame_t  rx_frame,
  input  logic    code_err,
  output wb_rsp_t wb_rsp,
  output frame_t  tx_frame,
  output logic    tx_start,
  output logic    irq
);

  logic        ack_q;
  logic [31:0] rd_dat_q;
  logic [31:0] tx0_q;
  logic [31:0] tx1_q;
  logic [11:0] tx2_q;         // Only bits 75:64 exist
  frame_t      rx_frame_q;
  logic        rx_valid;
  logic        err_sticky;
  logic        access;
  logic        wr_en;
  reg_addr_e   addr;

  // New access only while ack is low, so each cycle gets one ack
  assign access = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_en  = access && wb_req.we;
  assign addr   = reg_addr_e'(wb_req.adr);

  always_ff @(posedge clk_40) begin
    if (reset) begin
      ack_q    <= 1'b0;
      tx_start <= 1'b0;
    end else begin
      ack_q    <= access;
      tx_start <= wr_en && (addr == ctrl) && wb_req.dat[0] && !tx_busy;
    end
  end

  always_ff @(posedge clk_40) begin
    if (wr_en) begin
      case (addr)
        tx0:     tx0_q <= wb_req.dat;
        tx1:     tx1_q <= wb_req.dat;
        tx2:     tx2_q <= wb_req.dat[11:0];
        default: ;
      endcase
    end
  end

  // Sticky status, a new frame wins over a clear in the same clock
  always_ff @(posedge clk_40) begin
    if (reset) begin
      rx_valid   <= 1'b0;
      err_sticky <= 1'b0;
    end else begin
      if (wr_en && (addr == ctrl) && wb_req.dat[1]) begin
        rx_valid   <= 1'b0;
        err_sticky <= 1'b0;
      end
      if (rx_frame_valid) rx_valid <= 1'b1;
      if (code_err) err_sticky <= 1'b1;
    end
  end

  always_ff @(posedge clk_40) begin
    if (rx_frame_valid) rx_frame_q <= rx_frame;  // Overwrites an unread frame
  end

  always_ff @(posedge clk_40) begin
    if (access) begin
      case (addr)
        tx0:     rd_dat_q <= tx0_q;
        tx1:     rd_dat_q <= tx1_q;
        tx2:     rd_dat_q <= {20'b0, tx2_q};
        ctrl:    rd_dat_q <= {29'b0, err_sticky, rx_valid, tx_busy};
        rx0:     rd_dat_q <= rx_frame_q[31:0];
        rx1:     rd_dat_q <= rx_frame_q[63:32];
        rx2:     rd_dat_q <= {20'b0, rx_frame_q[75:64]};
        default: rd_dat_q <= '0;
      endcase
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_dat_q;
  assign tx_frame   = {tx2_q, tx1_q, tx0_q};
  assign irq        = rx_valid;

  // Ack answers a cycle that the master still holds
  ack_after_req: assert property (@(posedge clk_40) disable iff (reset)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb) && wb_req.cyc && wb_req.stb);

endmodule

// File: verilog/elink_framer.sv
`timescale 1ns/1ns
module elink_framer import elink_pkg::*; (
  input  logic    clk_40,
  input  logic    reset,
  input  logic    tx_start,
  input  frame_t  tx_frame,
  output symbol_t tx_sym,
  output logic    tx_busy
);

  localparam int cnt_w = $clog2(frame_bytes);

  framer_state_e            state;
  logic [cnt_w-1:0]         byte_cnt;
  logic [8*frame_bytes-1:0] frame_q;   // Zero padded to whole bytes

  always_ff @(posedge clk_40) begin
    if (reset) begin
      state    <= idle;
      byte_cnt <= '0;
    end else begin
      case (state)
        idle: if (tx_start) state <= sop;
        sop: begin
          state    <= data;
          byte_cnt <= '0;
        end
        data: begin
          if (byte_cnt == cnt_w'(frame_bytes - 1)) state <= eop;
          byte_cnt <= byte_cnt + 1'b1;
        end
        eop:     state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk_40) begin
    if (state == idle && tx_start) frame_q <= (8*frame_bytes)'(tx_frame);
  end

  // Least significant byte goes out first
  always_comb begin
    case (state)
      sop:     tx_sym = '{is_k: 1'b1, value: k28_1};
      data:    tx_sym = '{is_k: 1'b0, value: frame_q[8*byte_cnt +: 8]};
      eop:     tx_sym = '{is_k: 1'b1, value: k28_3};
      default: tx_sym = '{is_k: 1'b1, value: k28_5};  // Idle comma
    endcase
  end

  assign tx_busy = (state != idle);

  // Data bytes stay inside the latched frame
  no_k_in_data: assert property (@(posedge clk_40) disable iff (reset)
    (state == data) |-> !tx_sym.is_k && (byte_cnt < cnt_w'(frame_bytes)));

endmodule

// File: verilog/enc_8b10b.sv
`timescale 1ns/1ns
module enc_8b10b import elink_pkg::*; #(
  parameter bit reverse_bits = 1'b0
) (
  input  logic       clk_40,
  input  logic       reset,
  input  symbol_t    sym_in,
  output logic [9:0] code_out
);

  logic [4:0] x_val;
  logic [2:0] y_val;
  logic [5:0] tbl6;
  logic [3:0] tbl4;
  logic       rd_q;       // Running disparity, 1 is positive
  logic       rd_mid;
  logic       unbal6;
  logic       unbal4;
  logic       use_alt;
  logic       flip6;
  logic       flip4;
  logic [9:0] word;
  logic [9:0] word_rev;

  assign x_val = sym_in.value[4:0];
  assign y_val = sym_in.value[7:5];

  // 5b/6b, RD- column, abcdei
  always_comb begin
    case (x_val)
      5'd0:  tbl6 = 6'b100111;  5'd1:  tbl6 = 6'b011101;
      5'd2:  tbl6 = 6'b101101;  5'd3:  tbl6 = 6'b110001;
      5'd4:  tbl6 = 6'b110101;  5'd5:  tbl6 = 6'b101001;
      5'd6:  tbl6 = 6'b011001;  5'd7:  tbl6 = 6'b111000;
      5'd8:  tbl6 = 6'b111001;  5'd9:  tbl6 = 6'b100101;
      5'd10: tbl6 = 6'b010101;  5'd11: tbl6 = 6'b110100;
      5'd12: tbl6 = 6'b001101;  5'd13: tbl6 = 6'b101100;
      5'd14: tbl6 = 6'b011100;  5'd15: tbl6 = 6'b010111;
      5'd16: tbl6 = 6'b011011;  5'd17: tbl6 = 6'b100011;
      5'd18: tbl6 = 6'b010011;  5'd19: tbl6 = 6'b110010;
      5'd20: tbl6 = 6'b001011;  5'd21: tbl6 = 6'b101010;
      5'd22: tbl6 = 6'b011010;  5'd23: tbl6 = 6'b111010;
      5'd24: tbl6 = 6'b110011;  5'd25: tbl6 = 6'b100110;
      5'd26: tbl6 = 6'b010110;  5'd27: tbl6 = 6'b110110;
      5'd28: tbl6 = 6'b001110;  5'd29: tbl6 = 6'b101110;
      5'd30: tbl6 = 6'b011110;  default: tbl6 = 6'b101011;
    endcase
    if (sym_in.is_k) tbl6 = 6'b001111;  // Only K28.y is sent
  end

  assign unbal6 = ($countones(tbl6) != 3);
  assign flip6  = rd_q && (unbal6 || (x_val == 5'd7 && !sym_in.is_k));
  assign rd_mid = rd_q ^ unbal6;

  // Alternate D.x.7 avoids a run of five equal bits
  assign use_alt = sym_in.is_k ||
                   (!rd_mid && (x_val == 5'd17 || x_val == 5'd18 || x_val == 5'd20)) ||
                   (rd_mid && (x_val == 5'd11 || x_val == 5'd13 || x_val == 5'd14));

  // 3b/4b, RD- column, fghj
  always_comb begin
    case (y_val)
      3'd0:    tbl4 = 4'b1011;
      3'd1:    tbl4 = 4'b1001;
      3'd2:    tbl4 = 4'b0101;
      3'd3:    tbl4 = 4'b1100;
      3'd4:    tbl4 = 4'b1101;
      3'd5:    tbl4 = 4'b1010;
      3'd6:    tbl4 = 4'b0110;
      default: tbl4 = use_alt ? 4'b0111 : 4'b1110;
    endcase
  end

  assign unbal4 = ($countones(tbl4) != 2);

  // Balanced K sub-blocks take the complement at RD-
  always_comb begin
    if (sym_in.is_k && (y_val == 3'd1 || y_val == 3'd2 || y_val == 3'd5 || y_val == 3'd6))
      flip4 = !rd_mid;
    else
      flip4 = rd_mid && (unbal4 || y_val == 3'd3);
  end

  assign word     = {flip6 ? ~tbl6 : tbl6, flip4 ? ~tbl4 : tbl4};
  assign word_rev = {<<{word}};

  always_ff @(posedge clk_40) begin
    if (reset) rd_q <= 1'b0;
    else       rd_q <= rd_mid ^ unbal4;
  end

  always_ff @(posedge clk_40) begin
    code_out <= reverse_bits ? word_rev : word;
  end

  word_balance: assert property (@(posedge clk_40) disable iff (reset)
    ($countones(code_out) >= 4) && ($countones(code_out) <= 6));

endmodule

// File: verilog/dec_8b10b.sv
`timescale 1ns/1ns
module dec_8b10b import elink_pkg::*; #(
  parameter bit reverse_bits = 1'b0
) (
  input  logic       clk_40,
  input  logic       reset,
  input  logic [9:0] code_in,
  output symbol_t    sym_out,
  output logic       code_err
);

  logic [9:0] code_rev;
  logic [9:0] word;       // abcdei fghj, a at bit 9
  logic [5:0] abcdei;
  logic [3:0] fghj;
  logic [4:0] x_val;
  logic [2:0] y_val;
  logic       ok6;
  logic       ok4;
  logic       is_k28;
  logic       k_ok;
  logic [7:0] k_val;
  logic       valid;

  assign code_rev = {<<{code_in}};
  assign word     = reverse_bits ? code_rev : code_in;
  assign abcdei   = word[9:4];
  assign fghj     = word[3:0];

  always_comb begin
    ok6 = 1'b1;
    case (abcdei)
      6'b100111, 6'b011000: x_val = 5'd0;   6'b011101, 6'b100010: x_val = 5'd1;
      6'b101101, 6'b010010: x_val = 5'd2;   6'b110001:            x_val = 5'd3;
      6'b110101, 6'b001010: x_val = 5'd4;   6'b101001:            x_val = 5'd5;
      6'b011001:            x_val = 5'd6;   6'b111000, 6'b000111: x_val = 5'd7;
      6'b111001, 6'b000110: x_val = 5'd8;   6'b100101:            x_val = 5'd9;
      6'b010101:            x_val = 5'd10;  6'b110100:            x_val = 5'd11;
      6'b001101:            x_val = 5'd12;  6'b101100:            x_val = 5'd13;
      6'b011100:            x_val = 5'd14;  6'b010111, 6'b101000: x_val = 5'd15;
      6'b011011, 6'b100100: x_val = 5'd16;  6'b100011:            x_val = 5'd17;
      6'b010011:            x_val = 5'd18;  6'b110010:            x_val = 5'd19;
      6'b001011:            x_val = 5'd20;  6'b101010:            x_val = 5'd21;
      6'b011010:            x_val = 5'd22;  6'b111010, 6'b000101: x_val = 5'd23;
      6'b110011, 6'b001100: x_val = 5'd24;  6'b100110:            x_val = 5'd25;
      6'b010110:            x_val = 5'd26;  6'b110110, 6'b001001: x_val = 5'd27;
      6'b001110:            x_val = 5'd28;  6'b101110, 6'b010001: x_val = 5'd29;
      6'b011110, 6'b100001: x_val = 5'd30;  6'b101011, 6'b010100: x_val = 5'd31;
      default: begin
        x_val = 5'd0;
        ok6   = 1'b0;
      end
    endcase
  end

  always_comb begin
    ok4 = 1'b1;
    case (fghj)
      4'b1011, 4'b0100:                   y_val = 3'd0;
      4'b1001:                            y_val = 3'd1;
      4'b0101:                            y_val = 3'd2;
      4'b1100, 4'b0011:                   y_val = 3'd3;
      4'b1101, 4'b0010:                   y_val = 3'd4;
      4'b1010:                            y_val = 3'd5;
      4'b0110:                            y_val = 3'd6;
      4'b1110, 4'b0001, 4'b0111, 4'b1000: y_val = 3'd7;  // Primary and alternate
      default: begin
        y_val = 3'd0;
        ok4   = 1'b0;
      end
    endcase
  end

  // Only the three link K-codes are accepted
  always_comb begin
    k_ok = 1'b1;
    case (word)
      10'b0011111001, 10'b1100000110: k_val = k28_1;
      10'b0011110011, 10'b1100001100: k_val = k28_3;
      10'b0011111010, 10'b1100000101: k_val = k28_5;
      default: begin
        k_val = k28_5;
        k_ok  = 1'b0;
      end
    endcase
  end

  assign is_k28 = (abcdei == 6'b001111) || (abcdei == 6'b110000);
  assign valid  = is_k28 ? k_ok : (ok6 && ok4);

  always_ff @(posedge clk_40) begin
    if (reset) begin
      sym_out  <= '{is_k: 1'b1, value: k28_5};
      code_err <= 1'b0;
    end else begin
      code_err <= !valid;
      if (!valid)      sym_out <= '{is_k: 1'b1, value: k28_5};  // Bad word reads as idle
      else if (is_k28) sym_out <= '{is_k: 1'b1, value: k_val};
      else             sym_out <= '{is_k: 1'b0, value: {y_val, x_val}};
    end
  end

endmodule

// File: verilog/elink_deframer.sv
`timescale 1ns/1ns
module elink_deframer import elink_pkg::*; (
  input  logic    clk_40,
  input  logic    reset,
  input  symbol_t rx_sym,
  output frame_t  rx_frame,
  output logic    rx_frame_valid
);

  localparam int cnt_w = $clog2(frame_bytes + 1);

  deframer_state_e          state;
  logic [cnt_w-1:0]         byte_cnt;
  logic [8*frame_bytes-1:0] shreg;
  logic                     is_sop;
  logic                     is_eop;
  logic                     full;
  logic                     take;

  assign is_sop = rx_sym.is_k && (rx_sym.value == k28_1);
  assign is_eop = rx_sym.is_k && (rx_sym.value == k28_3);
  assign full   = (byte_cnt == cnt_w'(frame_bytes));
  assign take   = (state == collect) && !rx_sym.is_k && !full;

  always_ff @(posedge clk_40) begin
    if (reset) begin
      state          <= hunt;
      byte_cnt       <= '0;
      rx_frame_valid <= 1'b0;
    end else begin
      rx_frame_valid <= 1'b0;
      case (state)
        hunt: begin
          byte_cnt <= '0;
          if (is_sop) state <= collect;
        end
        default: begin
          if (take) begin
            byte_cnt <= byte_cnt + 1'b1;
          end else begin
            state          <= hunt;   // Any break in the sequence
            rx_frame_valid <= is_eop && full;
          end
        end
      endcase
    end
  end

  // First byte ends up in the low bits
  always_ff @(posedge clk_40) begin
    if (take) shreg <= {rx_sym.value, shreg[8*frame_bytes-1:8]};
  end

  assign rx_frame = shreg[$bits(frame_t)-1:0];

endmodule

// File: verilog/elink_core.sv
`timescale 1ns/1ns
module elink_core import elink_pkg::*; #(
  parameter bit reverse_bits = 1'b1
) (
  input  logic       clk_40,
  input  logic       reset,
  input  wb_req_t    wb_req,
  input  logic       loop_en,
  input  logic [9:0] line_in,
  output wb_rsp_t    wb_rsp,
  output logic [9:0] line_out,
  output logic       irq
);

  frame_t     tx_frame;
  frame_t     rx_frame;
  symbol_t    tx_sym;
  symbol_t    rx_sym;
  logic       tx_start;
  logic       tx_busy;
  logic       rx_frame_valid;
  logic       code_err;
  logic [9:0] dec_in;

  assign dec_in = loop_en ? line_out : line_in;  // Loopback select

  elink_wb_regs elink_wb_regs_i (
    .clk_40, .reset, .wb_req, .tx_busy, .rx_frame_valid, .rx_frame, .code_err,
    .wb_rsp, .tx_frame, .tx_start, .irq
  );

  elink_framer elink_framer_i (.clk_40, .reset, .tx_start, .tx_frame, .tx_sym, .tx_busy);

  enc_8b10b #(.reverse_bits(reverse_bits)) enc_8b10b_i (
    .clk_40, .reset, .sym_in(tx_sym), .code_out(line_out)
  );

  dec_8b10b #(.reverse_bits(reverse_bits)) dec_8b10b_i (
    .clk_40, .reset, .code_in(dec_in), .sym_out(rx_sym), .code_err
  );

  elink_deframer elink_deframer_i (.clk_40, .reset, .rx_sym, .rx_frame, .rx_frame_valid);

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ns
module clock_gen #(
  parameter int period       = 8,
  parameter int reset_cycles = 4
) (
  output logic clk_40,
  output logic reset
);

  initial begin
    clk_40 = 1'b0;
    forever #(period / 2) clk_40 = ~clk_40;
  end

  // Released on a rising edge, like any other stimulus
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk_40);
    reset <= 1'b0;
  end

endmodule

// File: sim/tb_elink_core.sv
`timescale 1ns/1ns
module tb_elink_core import elink_pkg::*; ();

  // Reverses the bit order of a line word, matches the DUT setting
  function automatic logic [9:0] bit_reverse(input logic [9:0] w);
    logic [9:0] r;
    for (int i = 0; i < 10; i++) r[i] = w[9 - i];
    return r;
  endfunction

  localparam bit         line_reversed = 1'b1;
  localparam int         ack_timeout   = 16;
  localparam int         irq_timeout   = 200;
  localparam int         seed          = 34593;
  localparam logic [9:0] k285_neg      = 10'b0011111010;  // abcdei fghj at RD-
  localparam logic [9:0] k285_pos      = 10'b1100000101;
  localparam logic [9:0] idle_neg      = line_reversed ? bit_reverse(k285_neg) : k285_neg;
  localparam logic [9:0] idle_pos      = line_reversed ? bit_reverse(k285_pos) : k285_pos;
  localparam logic [9:0] bad_word      = 10'b0000000000;  // No 8b10b code

  logic       clk_40;
  logic       reset;
  logic       reset_q = 1'b1;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  logic       loop_en;
  logic [9:0] line_in;
  logic [9:0] line_out;
  logic       irq;
  logic       watch_idle = 1'b0;
  int         rd_sum = -1;          // Ones minus zeros since reset
  int         err_cnt = 0;
  int         check_cnt = 0;
  int         err_mark = 0;

  clock_gen clock_gen_i (.clk_40, .reset);

  elink_core #(.reverse_bits(line_reversed)) elink_core_i (
    .clk_40, .reset, .wb_req, .loop_en, .line_in, .wb_rsp, .line_out, .irq
  );

  // First encoder word after reset is still the reset one
  always @(posedge clk_40) begin
    reset_q <= reset;
    if (reset || reset_q) rd_sum <= -1;
    else                  rd_sum <= rd_sum + 2 * $countones(line_out) - 10;
  end

  ack_one_clock: assert property (@(posedge clk_40) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      $display("wishbone acknowledge stayed high for more than one clock at %0t ns", $time);
      err_cnt = err_cnt + 1;
    end

  line_word_weight: assert property (@(posedge clk_40) disable iff (reset || reset_q)
    ($countones(line_out) >= 4) && ($countones(line_out) <= 6))
    else begin
      $display("line word %h at %0t ns has a number of ones outside 4 to 6",
               $sampled(line_out), $time);
      err_cnt = err_cnt + 1;
    end

  line_disparity: assert property (@(posedge clk_40) disable iff (reset || reset_q)
    (rd_sum == 1) || (rd_sum == -1))
    else begin
      $display("running disparity on the line reached %0d at %0t ns", $sampled(rd_sum), $time);
      err_cnt = err_cnt + 1;
    end

  idle_commas: assert property (@(posedge clk_40) disable iff (reset || reset_q)
    watch_idle |-> ((line_out == idle_neg) || (line_out == idle_pos)))
    else begin
      $display("error at %0t ns: line_out = %h, expected %h or %h",
               $time, $sampled(line_out), idle_neg, idle_pos);
      err_cnt = err_cnt + 1;
    end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp)
      else begin
        $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        err_cnt++;
      end
  endtask

  // One classic cycle, request held until acknowledge
  task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    @(posedge clk_40);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    n = 0;
    do begin
      @(posedge clk_40);
      n++;
    end while (!wb_rsp.ack && n < ack_timeout);
    rdat = wb_rsp.dat;
    if (!wb_rsp.ack) begin
      $display("wishbone cycle to address %0d got no acknowledge in %0d clocks", adr, n);
      err_cnt++;
    end
    wb_req <= '0;
  endtask

  task automatic write_reg(input logic [2:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic read_reg(input logic [2:0] adr, output logic [31:0] rdat);
    bus_cycle(1'b0, adr, '0, rdat);
  endtask

  task automatic wait_irq(input string what);
    int n;
    n = 0;
    while (!irq && n < irq_timeout) begin
      @(posedge clk_40);
      n++;
    end
    if (!irq) begin
      $display("%s: irq did not rise within %0d clocks", what, irq_timeout);
      err_cnt++;
    end
  endtask

  task automatic send_and_check(input logic [31:0] w0, w1, w2, input string what);
    logic [31:0] rd;
    write_reg(tx0, w0);
    write_reg(tx1, w1);
    write_reg(tx2, w2);
    write_reg(ctrl, 32'h1);
    wait_irq(what);
    read_reg(rx0, rd);
    check_value("rx0", rd, w0);
    read_reg(rx1, rd);
    check_value("rx1", rd, w1);
    read_reg(rx2, rd);
    check_value("rx2", rd, w2 & 32'hfff);
  endtask

  task automatic report_test(input string name);
    $display("%s finished with %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial begin
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] rd;
    int          n;
    wb_req  = '0;
    loop_en = 1'b1;
    line_in = idle_neg;
    void'($urandom(seed));

    @(posedge clk_40);
    n = 0;
    while (reset && n < 20) begin
      @(posedge clk_40);
      n++;
    end
    if (reset) begin
      $display("reset did not drop within 20 clocks");
      err_cnt++;
    end
    check_value("wb_rsp.ack", wb_rsp.ack, 0);
    check_value("irq", irq, 0);
    read_reg(ctrl, rd);
    check_value("ctrl", rd, 0);
    watch_idle <= 1'b1;
    repeat (16) @(posedge clk_40);  // Idle window
    watch_idle <= 1'b0;
    report_test("reset");

    w0 = $urandom;
    w1 = $urandom;
    w2 = $urandom;
    write_reg(tx0, w0);
    write_reg(tx1, w1);
    write_reg(tx2, w2);
    read_reg(tx0, rd);
    check_value("tx0", rd, w0);
    read_reg(tx1, rd);
    check_value("tx1", rd, w1);
    read_reg(tx2, rd);
    check_value("tx2", rd, w2 & 32'hfff);
    report_test("register read-back");

    for (int f = 0; f < 3; f++) begin
      send_and_check($urandom, $urandom, $urandom, "loopback frame");
      write_reg(ctrl, 32'h2);
      check_value("irq", irq, 0);
    end
    report_test("loopback frame");

    w0 = $urandom;
    w1 = $urandom;
    w2 = $urandom;
    write_reg(tx0, w0);
    write_reg(tx1, w1);
    write_reg(tx2, w2);
    write_reg(ctrl, 32'h1);
    n = 0;
    rd = '0;
    while (!rd[0] && n < ack_timeout) begin
      read_reg(ctrl, rd);
      n++;
    end
    if (!rd[0]) begin
      $display("ctrl never showed transmit busy after a start");
      err_cnt++;
    end
    write_reg(ctrl, 32'h1);         // Ignored while busy
    wait_irq("start while busy");
    read_reg(rx0, rd);
    check_value("rx0", rd, w0);
    read_reg(rx1, rd);
    check_value("rx1", rd, w1);
    read_reg(rx2, rd);
    check_value("rx2", rd, w2 & 32'hfff);
    write_reg(ctrl, 32'h2);
    repeat (40) @(posedge clk_40);  // Room for a second frame to show up
    check_value("irq", irq, 0);
    report_test("start while busy");

    // Frames above already ran through the line checks
    send_and_check($urandom, $urandom, $urandom, "line code rules");
    write_reg(ctrl, 32'h2);
    report_test("line code rules");

    @(posedge clk_40);
    loop_en <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk_40);
      line_in <= (i % 2 == 1) ? idle_pos : idle_neg;
    end
    read_reg(ctrl, rd);
    check_value("ctrl", rd, 0);
    @(posedge clk_40);
    line_in <= bad_word;
    @(posedge clk_40);
    line_in <= idle_neg;
    repeat (4) @(posedge clk_40);
    read_reg(ctrl, rd);
    check_value("ctrl", rd, 32'h4);  // Code error only
    report_test("external input error");

    $display("tests: 6, checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
verilog/elink_pkg.sv
verilog/elink_wb_regs.sv
verilog/elink_framer.sv
verilog/enc_8b10b.sv
verilog/dec_8b10b.sv
verilog/elink_deframer.sv
verilog/elink_core.sv
sim/clock_gen.sv
sim/tb_elink_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_elink_core
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
